// ==== logic/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ***********************************************************
// Execute section dimensions
// ***********************************************************

// Data path width
`define XLEN 32

`define REG_AW 5    // Architectural register index

// Instructions issued per cycle
`define ISSUE_W 2

`define UOP_W 5     // Holds every operation code of uop_e

`endif

// ==== logic/uop_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package uop_pkg;

    // ***********************************************************
    // Operation codes seen by the execute stages
    // ***********************************************************
    typedef enum logic [`UOP_W-1:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_NOR,
        UOP_SLL,
        UOP_SRL,
        UOP_SRA,
        UOP_SLT,
        UOP_SLTU,
        UOP_LUI,
        UOP_MUL,    // Low word of the product
        UOP_MULH,   // High word, signed
        UOP_MULHU   // High word, unsigned
    } uop_e;

    // Exceptions raised before execute, carried to writeback
    typedef struct packed {
        logic syscall;
        logic brk;
        logic priv;
    } exc_flags_t;

endpackage

`default_nettype wire

// ==== logic/exec_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

    import uop_pkg::*;

    // Slot as delivered by decode and operand read
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   inst;
        uop_e               uop;
        exc_flags_t         exc;
        logic [`XLEN-1:0]   src_a;
        logic [`XLEN-1:0]   src_b;
        logic [`XLEN-1:0]   imm;
        logic               use_imm;   // Second operand is imm
        logic [`REG_AW-1:0] rd;
    } issue_slot_t;

    typedef issue_slot_t [`ISSUE_W-1:0] issue_pair_t;

    // 16x16 partial products and signed correction
    typedef struct packed {
        logic [`XLEN-1:0] hh;
        logic [`XLEN-1:0] hl;
        logic [`XLEN-1:0] lh;
        logic [`XLEN-1:0] ll;
        logic [`XLEN-1:0] comp;
    } mul_part_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        uop_e               uop;
        exc_flags_t         exc;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   alu_res;
        logic               alu_valid;
        mul_part_t          mul;
    } ex1_slot_t;

    typedef ex1_slot_t [`ISSUE_W-1:0] ex1_pair_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        logic               we;
        exc_flags_t         exc;
    } wb_slot_t;

    typedef wb_slot_t [`ISSUE_W-1:0] wb_pair_t;

endpackage

`default_nettype wire

// ==== logic/pipe_stage_reg.sv ====
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     prev_valid,
    input  payload_t prev_data,
    output logic     allowin,
    input  logic     next_allowin,
    output logic     valid,
    output payload_t data
);

    logic take;

    // Every stage finishes in one cycle, so readygo is always true
    assign allowin = !flush && (!valid || next_allowin);
    assign take    = prev_valid && allowin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;              // Drop whatever is in flight
        end else if (allowin) begin
            valid <= prev_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data <= '0;
        end else if (take) begin
            data <= prev_data;
        end else if (flush || (valid && next_allowin)) begin
            data <= '0;                 // Empty slot reads as zero
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
`default_nettype none

`include "exec_config.svh"

module alu_unit (
    input  exec_pkg::issue_slot_t slot,
    output logic [`XLEN-1:0]      res,
    output logic                  res_valid
);

    import uop_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [SHW-1:0]   shamt;
    logic             lt_s;
    logic             lt_u;

    assign op_a  = slot.src_a;
    assign op_b  = slot.use_imm ? slot.imm : slot.src_b;
    assign shamt = op_b[SHW-1:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // ***********************************************************
    // Operation select
    // ***********************************************************
    always_comb begin
        res       = '0;
        res_valid = 1'b1;
        case (slot.uop)
            UOP_ADD: begin
                res = op_a + op_b;
            end
            UOP_SUB: begin
                res = op_a - op_b;
            end
            UOP_AND: begin
                res = op_a & op_b;
            end
            UOP_OR: begin
                res = op_a | op_b;
            end
            UOP_XOR: begin
                res = op_a ^ op_b;
            end
            UOP_NOR: begin
                res = ~(op_a | op_b);
            end
            UOP_SLL: begin
                res = op_a << shamt;
            end
            UOP_SRL: begin
                res = op_a >> shamt;
            end
            UOP_SRA: begin
                res = $signed(op_a) >>> shamt;
            end
            UOP_SLT: begin
                res = {{(`XLEN-1){1'b0}}, lt_s};
            end
            UOP_SLTU: begin
                res = {{(`XLEN-1){1'b0}}, lt_u};
            end
            UOP_LUI: begin
                res = {op_b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};   // Upper half load
            end
            default: begin
                res_valid = 1'b0;       // NOP and multiplies
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mul_partial.sv ====
`default_nettype none

`include "exec_config.svh"

module mul_partial (
    input  exec_pkg::issue_slot_t slot,
    output exec_pkg::mul_part_t   part
);

    import uop_pkg::*;

    localparam int HALF = `XLEN / 2;

    logic [HALF-1:0]  a_hi;
    logic [HALF-1:0]  a_lo;
    logic [HALF-1:0]  b_hi;
    logic [HALF-1:0]  b_lo;
    logic [`XLEN-1:0] comp_a;
    logic [`XLEN-1:0] comp_b;

    assign a_hi = slot.src_a[`XLEN-1:HALF];
    assign a_lo = slot.src_a[HALF-1:0];
    assign b_hi = slot.src_b[`XLEN-1:HALF];
    assign b_lo = slot.src_b[HALF-1:0];

    // Signed high word = unsigned high word minus these terms
    assign comp_a = slot.src_a[`XLEN-1] ? slot.src_b : '0;
    assign comp_b = slot.src_b[`XLEN-1] ? slot.src_a : '0;

    always_comb begin
        part.hh   = a_hi * b_hi;
        part.hl   = a_hi * b_lo;
        part.lh   = a_lo * b_hi;
        part.ll   = a_lo * b_lo;
        part.comp = '0;
        if (slot.uop == UOP_MULH) begin
            part.comp = comp_a + comp_b;    // Wraps modulo 2^XLEN
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_combine.sv ====
`default_nettype none

`include "exec_config.svh"

module mul_combine (
    input  uop_pkg::uop_e       uop,
    input  exec_pkg::mul_part_t part,
    output logic [`XLEN-1:0]    res
);

    import uop_pkg::*;

    localparam int HALF = `XLEN / 2;
    localparam int PW   = 2 * `XLEN;

    logic [PW-1:0] prod;

    // hh and ll never overlap, so they concatenate
    assign prod = {part.hh, part.ll}
                + (PW'(part.hl) << HALF)
                + (PW'(part.lh) << HALF);

    always_comb begin
        case (uop)
            UOP_MUL:   res = prod[`XLEN-1:0];
            UOP_MULHU: res = prod[PW-1:`XLEN];
            UOP_MULH:  res = prod[PW-1:`XLEN] - part.comp;
            default:   res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/exec_pipe.sv ====
`default_nettype none

`include "exec_config.svh"

module exec_pipe (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    input  exec_pkg::issue_pair_t in_pair,
    output logic                  in_allowin,
    output logic                  wb_valid,
    output exec_pkg::wb_pair_t    wb_pair,
    input  logic                  wb_allowin
);

    import uop_pkg::*;
    import exec_pkg::*;

    logic        ex1_valid;
    logic        ex1_allowin;
    logic        ex2_valid;
    logic        ex2_allowin;
    issue_pair_t ex1_pair_q;
    ex1_pair_t   ex1_pair_d;
    ex1_pair_t   ex2_pair_q;
    wb_pair_t    wb_pair_d;

    logic      [`ISSUE_W-1:0][`XLEN-1:0] alu_res;
    logic      [`ISSUE_W-1:0]            alu_valid;
    mul_part_t [`ISSUE_W-1:0]            mul_part;
    logic      [`ISSUE_W-1:0][`XLEN-1:0] mul_res;

    pipe_stage_reg #(.payload_t(issue_pair_t)) reg_ex1 (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .prev_valid   (in_valid),
        .prev_data    (in_pair),
        .allowin      (in_allowin),
        .next_allowin (ex1_allowin),
        .valid        (ex1_valid),
        .data         (ex1_pair_q)
    );

    // ***********************************************************
    // EX1 : ALU and multiply partials
    // ***********************************************************
    alu_unit alu_slot0 (.slot(ex1_pair_q[0]), .res(alu_res[0]), .res_valid(alu_valid[0]));
    alu_unit alu_slot1 (.slot(ex1_pair_q[1]), .res(alu_res[1]), .res_valid(alu_valid[1]));

    mul_partial mul_slot0 (.slot(ex1_pair_q[0]), .part(mul_part[0]));
    mul_partial mul_slot1 (.slot(ex1_pair_q[1]), .part(mul_part[1]));

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            ex1_pair_d[i].pc        = ex1_pair_q[i].pc;
            ex1_pair_d[i].uop       = ex1_pair_q[i].uop;
            ex1_pair_d[i].exc       = ex1_pair_q[i].exc;
            ex1_pair_d[i].rd        = ex1_pair_q[i].rd;
            ex1_pair_d[i].alu_res   = alu_res[i];
            ex1_pair_d[i].alu_valid = alu_valid[i];
            ex1_pair_d[i].mul       = mul_part[i];
        end
    end

    pipe_stage_reg #(.payload_t(ex1_pair_t)) ex1_ex2 (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .prev_valid   (ex1_valid),
        .prev_data    (ex1_pair_d),
        .allowin      (ex1_allowin),
        .next_allowin (ex2_allowin),
        .valid        (ex2_valid),
        .data         (ex2_pair_q)
    );

    // ***********************************************************
    // EX2 : product combine and result select
    // ***********************************************************
    mul_combine comb_slot0 (.uop(ex2_pair_q[0].uop), .part(ex2_pair_q[0].mul), .res(mul_res[0]));
    mul_combine comb_slot1 (.uop(ex2_pair_q[1].uop), .part(ex2_pair_q[1].mul), .res(mul_res[1]));

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            wb_pair_d[i].pc   = ex2_pair_q[i].pc;
            wb_pair_d[i].rd   = ex2_pair_q[i].rd;
            wb_pair_d[i].exc  = ex2_pair_q[i].exc;
            wb_pair_d[i].data = ex2_pair_q[i].alu_valid ? ex2_pair_q[i].alu_res : mul_res[i];
            // Any raised exception cancels the register write
            wb_pair_d[i].we   = (ex2_pair_q[i].uop != UOP_NOP)
                              && (ex2_pair_q[i].rd != '0)
                              && (ex2_pair_q[i].exc == '0);
        end
    end

    pipe_stage_reg #(.payload_t(wb_pair_t)) ex2_wb (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .prev_valid   (ex2_valid),
        .prev_data    (wb_pair_d),
        .allowin      (ex2_allowin),
        .next_allowin (wb_allowin),
        .valid        (wb_valid),
        .data         (wb_pair)
    );

endmodule

`default_nettype wire

// ==== sim/exec_tb_table.svh ====
`ifndef EXEC_TB_TABLE_SVH
`define EXEC_TB_TABLE_SVH

// Columns: uop, exc, src_a, src_b, imm, use_imm, rd, expected data
// Two lines per pair, slot 0 then slot 1
localparam int NUM_PAIRS = 12;

vec_slot_t vec_tbl [2*NUM_PAIRS] = '{
    '{UOP_ADD,   3'b000, 32'h00000005, 32'h00000003, 32'h00000000, 1'b0, 5'd1,  32'h00000008},
    '{UOP_SUB,   3'b000, 32'h00000003, 32'h00000005, 32'h00000000, 1'b0, 5'd2,  32'hfffffffe},
    '{UOP_AND,   3'b000, 32'hf0f01234, 32'h0ff0ff00, 32'h00000000, 1'b0, 5'd3,  32'h00f01200},
    '{UOP_OR,    3'b000, 32'h12340000, 32'hffffffff, 32'h0000abcd, 1'b1, 5'd4,  32'h1234abcd},
    '{UOP_XOR,   3'b000, 32'haaaa5555, 32'hffff0000, 32'h00000000, 1'b0, 5'd5,  32'h55555555},
    '{UOP_NOR,   3'b000, 32'h0f0f0000, 32'h00f0000f, 32'h00000000, 1'b0, 5'd6,  32'hf000fff0},
    '{UOP_SLL,   3'b000, 32'h00000001, 32'h00000024, 32'h00000000, 1'b0, 5'd7,  32'h00000010},
    '{UOP_SRL,   3'b000, 32'h80000000, 32'h00000000, 32'h0000001f, 1'b1, 5'd8,  32'h00000001},
    '{UOP_SRA,   3'b000, 32'h80000010, 32'h00000004, 32'h00000000, 1'b0, 5'd9,  32'hf8000001},
    '{UOP_SLT,   3'b000, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0, 5'd10, 32'h00000001},
    '{UOP_SLTU,  3'b000, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0, 5'd11, 32'h00000000},
    '{UOP_LUI,   3'b000, 32'h00000000, 32'h0000ffff, 32'h00001234, 1'b1, 5'd12, 32'h12340000},
    // Multiplies, most negative value included
    '{UOP_MUL,   3'b000, 32'h00012345, 32'h00000010, 32'h00000000, 1'b0, 5'd13, 32'h00123450},
    '{UOP_MULHU, 3'b000, 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b0, 5'd14, 32'hfffffffe},
    '{UOP_MULH,  3'b000, 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b0, 5'd15, 32'h00000000},
    '{UOP_MULH,  3'b000, 32'h80000000, 32'h80000000, 32'h00000000, 1'b0, 5'd16, 32'h40000000},
    '{UOP_MULH,  3'b000, 32'h80000000, 32'h00000002, 32'h00000000, 1'b0, 5'd17, 32'hffffffff},
    '{UOP_MUL,   3'b000, 32'hfffffffd, 32'h00000007, 32'h00000000, 1'b0, 5'd18, 32'hffffffeb},
    '{UOP_MULHU, 3'b000, 32'h80000000, 32'h00000003, 32'h00000000, 1'b0, 5'd19, 32'h00000001},
    '{UOP_MULH,  3'b000, 32'h7fffffff, 32'h80000000, 32'h00000000, 1'b0, 5'd20, 32'hc0000000},
    // No register write: flags, NOP, rd zero
    '{UOP_ADD,   3'b100, 32'h00000001, 32'h00000001, 32'h00000000, 1'b0, 5'd21, 32'h00000002},
    '{UOP_NOP,   3'b000, 32'h00000005, 32'h00000006, 32'h00000000, 1'b0, 5'd22, 32'h00000000},
    '{UOP_ADD,   3'b000, 32'h00000007, 32'h00000008, 32'h00000000, 1'b0, 5'd0,  32'h0000000f},
    '{UOP_XOR,   3'b011, 32'h000000ff, 32'h0000000f, 32'h00000000, 1'b0, 5'd23, 32'h000000f0}
};

`endif

// ==== sim/exec_pipe_tb.sv ====
`default_nettype none

`include "exec_config.svh"

module exec_pipe_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import uop_pkg::*;
    import exec_pkg::*;

    localparam int LIMIT = 400;     // Cycles allowed for one wait loop

    typedef struct packed {
        uop_e               uop;
        exc_flags_t         exc;
        logic [`XLEN-1:0]   src_a;
        logic [`XLEN-1:0]   src_b;
        logic [`XLEN-1:0]   imm;
        logic               use_imm;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   exp_data;
    } vec_slot_t;

    `include "exec_tb_table.svh"

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        in_valid;
    issue_pair_t in_pair;
    logic        in_allowin;
    logic        wb_valid;
    wb_pair_t    wb_pair;
    logic        wb_allowin;

    integer      seed = 32'h3e00_bb86;
    int          errors;
    int          tests;
    int          failed;
    int unsigned cycle;
    logic        timed_out;
    logic        held;          // Output stalled on the last edge
    wb_pair_t    held_pair;
    wb_pair_t    exp_q[$];
    int unsigned cyc_q[$];      // Acceptance cycle of each queued pair

    exec_pipe dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pair    (in_pair),
        .in_allowin (in_allowin),
        .wb_valid   (wb_valid),
        .wb_pair    (wb_pair),
        .wb_allowin (wb_allowin)
    );

    always #20 clk = ~clk;

    // ***********************************************************
    // Stimulus and expected pairs from the table
    // ***********************************************************
    function automatic issue_pair_t build_pair(int row);
        issue_pair_t p;
        vec_slot_t   v;
        for (int s = 0; s < `ISSUE_W; s++) begin
            v = vec_tbl[2*row+s];
            p[s].pc      = 32'h0000_1000 + 8*row + 4*s;
            p[s].inst    = '0;
            p[s].uop     = v.uop;
            p[s].exc     = v.exc;
            p[s].src_a   = v.src_a;
            p[s].src_b   = v.src_b;
            p[s].imm     = v.imm;
            p[s].use_imm = v.use_imm;
            p[s].rd      = v.rd;
        end
        return p;
    endfunction

    function automatic wb_pair_t expect_pair(int row);
        wb_pair_t  w;
        vec_slot_t v;
        for (int s = 0; s < `ISSUE_W; s++) begin
            v = vec_tbl[2*row+s];
            w[s].pc   = 32'h0000_1000 + 8*row + 4*s;
            w[s].rd   = v.rd;
            w[s].data = v.exp_data;
            w[s].we   = v.uop != UOP_NOP && v.rd != '0 && v.exc == '0;   // No write on a flag
            w[s].exc  = v.exc;
        end
        return w;
    endfunction

    // One cycle: drive at the falling edge, then check what the next edge will move
    task automatic step(input logic vld, input int row, input logic allow, input logic fl,
                        input logic lat_chk, output logic taken);
        in_valid   = vld;
        in_pair    = build_pair(row);
        wb_allowin = allow;
        flush      = fl;
        #1;
        if (held) begin
            assert (wb_valid && wb_pair == held_pair) else begin
                $display("** Error: wb_pair moved while stalled, expected %h got %h",
                         held_pair, wb_pair);
                errors++;
            end
        end
        held      = wb_valid && !allow && !fl;
        held_pair = wb_pair;
        if (wb_valid && allow) begin
            assert (exp_q.size() > 0) else begin
                $display("Output pair appeared with nothing in flight");
                errors++;
            end
            if (exp_q.size() > 0) begin
                assert (wb_pair == exp_q[0]) else begin
                    $display("** Error: wb_pair expected %h got %h", exp_q[0], wb_pair);
                    errors++;
                end
                assert (!lat_chk || cycle - cyc_q[0] == 3) else begin
                    $display("Pair retired %0d cycles after acceptance", cycle - cyc_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
            end
        end
        taken = vld && in_allowin;
        if (taken) begin
            exp_q.push_back(expect_pair(row));
            cyc_q.push_back(cycle);
        end
        @(negedge clk);
        cycle++;
    endtask

    task automatic stream(input int first, input int last, input logic bp);
        int   row;
        int   n;
        logic vld;
        logic allow;
        logic taken;
        row = first;
        n   = 0;
        while ((row <= last || exp_q.size() > 0) && n < LIMIT && !timed_out) begin
            vld   = row <= last && (!bp || $random(seed) % 4 != 0);
            allow = !bp || $random(seed) % 3 != 0;
            step(vld, (row <= last) ? row : last, allow, 1'b0, !bp, taken);
            // Open output means one pair per cycle
            assert (bp || !vld || taken) else begin
                $display("Pair refused while the output was open");
                errors++;
            end
            if (taken) begin
                row++;
            end
            n++;
        end
        if (row <= last || exp_q.size() > 0) begin
            $display("Timeout after %0d cycles with %0d pairs still in flight", n, exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        if (errors != mark) begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - mark);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    task automatic run_test(input string name, input int first, input int last, input logic bp);
        int mark;
        mark = errors;
        stream(first, last, bp);
        finish_test(name, mark);
    endtask

    task automatic flush_test();
        int   mark;
        logic taken;
        mark = errors;
        for (int r = 0; r < 3; r++) begin
            step(1'b1, r, 1'b0, 1'b0, 1'b0, taken);     // Fill while the consumer stalls
        end
        step(1'b1, 3, 1'b1, 1'b1, 1'b0, taken);         // Consumer open, only flush refuses
        assert (!taken) else begin
            $display("A pair was accepted in the flush cycle");
            errors++;
        end
        exp_q.delete();
        cyc_q.delete();
        for (int i = 0; i < 4; i++) begin
            step(1'b0, 0, 1'b1, 1'b0, 1'b0, taken);     // Any output here is a flushed pair
        end
        stream(0, 3, 1'b0);
        finish_test("flush", mark);
    endtask

    // ***********************************************************
    // Test sequence
    // ***********************************************************
    initial begin
        int mark;
        clk        = 1'b0;
        arst_n     = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_pair    = '0;
        wb_allowin = 1'b0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        cycle      = 0;
        timed_out  = 1'b0;
        held       = 1'b0;
        held_pair  = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        mark   = errors;
        assert (!wb_valid && wb_pair == '0 && in_allowin) else begin
            $display("Pipe is not empty and open after reset");
            errors++;
        end
        finish_test("reset", mark);
        run_test("alu", 0, 5, 1'b0);
        run_test("multiply", 6, 9, 1'b0);
        run_test("no_write", 10, 11, 1'b0);
        run_test("back_to_back", 0, NUM_PAIRS - 1, 1'b0);
        run_test("backpressure", 0, NUM_PAIRS - 1, 1'b1);
        flush_test();
        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
+incdir+sim
logic/uop_pkg.sv
logic/exec_pkg.sv
logic/pipe_stage_reg.sv
logic/alu_unit.sv
logic/mul_partial.sv
logic/mul_combine.sv
logic/exec_pipe.sv
sim/exec_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module exec_pipe_tb \
    -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/Vexec_pipe_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1
